// ==== Bender.yml ====
package:
  name: xalu

sources:
  - source/xalu_data_pkg.sv
  - source/xalu_op_pkg.sv
  - source/xalu_multiplier.sv
  - source/xalu_divider.sv
  - source/xalu_hilo_unit.sv
  - source/xalu_top.sv
  - target: test
    files:
      - bench/xalu_props.sv
      - bench/tb_xalu.sv

// ==== bench/tb_xalu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_xalu;

    logic                     clk;
    logic                     reset;
    logic                     issue_valid;
    xalu_op_pkg::xalu_issue_t issue;
    logic                     flush;
    xalu_data_pkg::word_t     hi;
    xalu_data_pkg::word_t     lo;
    logic                     busy;

    logic [31:0]              rng_state;
    xalu_data_pkg::word_t     exp_hi;        // reference copy of hi/lo
    xalu_data_pkg::word_t     exp_lo;
    int                       errors;
    int                       prop_seen;     // bound assertion failures already counted
    int                       tests_run;
    int                       tests_bad;

    xalu_top i_dut (
        .clk           (clk),
        .reset         (reset),
        .issue_valid_i (issue_valid),
        .issue_i       (issue),
        .flush_i       (flush),
        .hi_o          (hi),
        .lo_o          (lo),
        .busy_o        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic xalu_data_pkg::word_t draw_operand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        case (rng_state[2:0])
            3'd0:    return 32'h0;
            3'd1:    return 32'h1;
            3'd2:    return 32'hffff_ffff;
            3'd3:    return 32'h8000_0000;     // most negative
            default: return rng_state ^ {rng_state[15:0], rng_state[31:16]};
        endcase
    endfunction

    // expected {hi, lo} after one operation
    function automatic xalu_data_pkg::dword_t model(xalu_op_pkg::xalu_op_t op,
                                                    xalu_data_pkg::word_t a,
                                                    xalu_data_pkg::word_t b,
                                                    xalu_data_pkg::dword_t old);
        logic signed [63:0]   prod;
        logic                 sgn;
        xalu_data_pkg::word_t ma;
        xalu_data_pkg::word_t mb;
        xalu_data_pkg::word_t q;
        xalu_data_pkg::word_t r;
        sgn  = op inside {xalu_op_pkg::OP_MULT, xalu_op_pkg::OP_MADD,
                          xalu_op_pkg::OP_MSUB, xalu_op_pkg::OP_DIV};
        prod = sgn ? {{32{a[31]}}, a} * {{32{b[31]}}, b} : {32'h0, a} * {32'h0, b};
        case (op)
            xalu_op_pkg::OP_MULT, xalu_op_pkg::OP_MULTU: return prod;
            xalu_op_pkg::OP_MADD, xalu_op_pkg::OP_MADDU: return old + prod;
            xalu_op_pkg::OP_MSUB, xalu_op_pkg::OP_MSUBU: return old - prod;
            xalu_op_pkg::OP_DIV, xalu_op_pkg::OP_DIVU: begin
                ma = (sgn && a[31]) ? -a : a;
                mb = (sgn && b[31]) ? -b : b;
                q  = (mb == 0) ? 32'hffff_ffff : ma / mb;
                r  = (mb == 0) ? ma : ma % mb;
                if (sgn && (a[31] ^ b[31])) q = -q;
                if (sgn && a[31]) r = -r;          // sign of the dividend
                return {r, q};
            end
            xalu_op_pkg::OP_MTHI: return {a, old[31:0]};
            xalu_op_pkg::OP_MTLO: return {old[63:32], a};
            default: return old;
        endcase
    endfunction

    task automatic check_regs(string what);
        assert (hi === exp_hi && lo === exp_lo) else begin
            $display("[ERROR] %0t %s: hi/lo %h_%h, expected %h_%h",
                     $time, what, hi, lo, exp_hi, exp_lo);
            errors++;
        end
    endtask

    task automatic wait_idle(output int cycles);
        cycles = 0;
        while (busy && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            $display("timeout at %0t: busy never cleared", $time);
            errors++;
        end
    endtask

    // one cycle of issue_valid, starting and ending on a falling edge
    task automatic present(xalu_op_pkg::xalu_op_t op, xalu_data_pkg::word_t a,
                           xalu_data_pkg::word_t b);
        issue_valid = 1'b1;
        issue.op    = op;
        issue.a     = a;
        issue.b     = b;
        @(negedge clk);
        issue_valid = 1'b0;
        issue.op    = xalu_op_pkg::OP_NOP;
    endtask

    task automatic run_op(xalu_op_pkg::xalu_op_t op, xalu_data_pkg::word_t a,
                          xalu_data_pkg::word_t b);
        xalu_data_pkg::dword_t expv;
        int                    cycles;
        int                    want;
        expv = model(op, a, b, {exp_hi, exp_lo});
        if (op inside {xalu_op_pkg::OP_DIV, xalu_op_pkg::OP_DIVU}) begin
            want = 34;
        end else if (op inside {xalu_op_pkg::OP_MTHI, xalu_op_pkg::OP_MTLO}) begin
            want = 0;
        end else begin
            want = 9;
        end
        present(op, a, b);
        wait_idle(cycles);
        assert (cycles == want) else begin
            $display("[ERROR] %0t %s: busy for %0d cycles, expected %0d",
                     $time, op.name(), cycles, want);
            errors++;
        end
        {exp_hi, exp_lo} = expv;
        check_regs($sformatf("%s %h %h", op.name(), a, b));
    endtask

    task automatic collect_prop_failures();
        errors    = errors + i_dut.i_hilo.i_props.fail_count - prop_seen;
        prop_seen = i_dut.i_hilo.i_props.fail_count;
    endtask

    task automatic close_test(string name, int errs_before);
        collect_prop_failures();
        tests_run++;
        if (errors > errs_before) begin
            tests_bad++;
            $display("test %s: FAIL", name);
        end else begin
            $display("test %s: PASS", name);
        end
    endtask

    initial begin
        xalu_data_pkg::word_t a;
        xalu_data_pkg::word_t b;
        int                   e0;
        int                   cycles;
        xalu_op_pkg::xalu_op_t acc_ops[4];
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        flush       = 1'b0;
        rng_state   = 32'h42d8a045;
        exp_hi      = '0;
        exp_lo      = '0;
        errors      = 0;
        prop_seen   = 0;
        tests_run   = 0;
        tests_bad   = 0;
        acc_ops     = '{xalu_op_pkg::OP_MADD, xalu_op_pkg::OP_MADDU,
                        xalu_op_pkg::OP_MSUB, xalu_op_pkg::OP_MSUBU};
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_regs("after reset");

        e0 = errors;
        for (int i = 0; i < 16; i++) begin
            a = draw_operand();
            b = draw_operand();
            run_op(i[0] ? xalu_op_pkg::OP_MULTU : xalu_op_pkg::OP_MULT, a, b);
        end
        close_test("mult/multu", e0);

        e0 = errors;
        for (int i = 0; i < 12; i++) begin
            a = draw_operand();
            b = draw_operand();
            run_op(xalu_op_pkg::OP_MTHI, a, 32'h0);
            run_op(xalu_op_pkg::OP_MTLO, b, 32'h0);
            a = draw_operand();
            b = draw_operand();
            run_op(acc_ops[i % 4], a, b);
        end
        close_test("madd/msub", e0);

        e0 = errors;
        run_op(xalu_op_pkg::OP_DIV, 32'h8000_0000, 32'hffff_ffff);   // wraps
        run_op(xalu_op_pkg::OP_DIV, 32'hffff_fff9, 32'h0);
        run_op(xalu_op_pkg::OP_DIVU, 32'h1234_5678, 32'h0);
        run_op(xalu_op_pkg::OP_DIV, 32'hffff_fff9, 32'h2);
        for (int i = 0; i < 12; i++) begin
            a = draw_operand();
            b = draw_operand();
            run_op(i[0] ? xalu_op_pkg::OP_DIVU : xalu_op_pkg::OP_DIV, a, b);
        end
        close_test("div/divu", e0);

        e0 = errors;
        run_op(xalu_op_pkg::OP_MTHI, 32'hcafe_0001, 32'h0);
        run_op(xalu_op_pkg::OP_MTLO, 32'h0bad_f00d, 32'h0);
        run_op(xalu_op_pkg::OP_MTHI, 32'h0000_0042, 32'h0);
        close_test("mthi/mtlo", e0);

        e0 = errors;
        {exp_hi, exp_lo} = model(xalu_op_pkg::OP_MULT, 32'hffff_fffd, 32'h7, 64'h0);
        present(xalu_op_pkg::OP_MULT, 32'hffff_fffd, 32'h7);
        issue_valid = 1'b1;                  // second issue held while busy
        issue.op    = xalu_op_pkg::OP_DIVU;
        issue.a     = 32'h0000_1000;
        issue.b     = 32'h3;
        repeat (4) @(negedge clk);
        issue_valid = 1'b0;
        issue.op    = xalu_op_pkg::OP_NOP;
        wait_idle(cycles);
        check_regs("issue while busy");
        close_test("issue while busy", e0);

        e0 = errors;
        present(xalu_op_pkg::OP_MULT, 32'h0000_1111, 32'h0000_2222);
        repeat (3) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        assert (!busy) else begin
            $display("[ERROR] %0t busy still set after flush of multiply", $time);
            errors++;
        end
        repeat (34) @(negedge clk);          // well past where the multiply would end
        check_regs("flush multiply");
        present(xalu_op_pkg::OP_DIVU, 32'h0000_ffff, 32'h0000_0010);
        repeat (12) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        assert (!busy) else begin
            $display("[ERROR] %0t busy still set after flush of divide", $time);
            errors++;
        end
        repeat (34) @(negedge clk);          // past the original divide completion
        check_regs("flush divide");
        run_op(xalu_op_pkg::OP_MADD, 32'h0000_0003, 32'hffff_fffe);
        run_op(xalu_op_pkg::OP_DIV, 32'h0000_0064, 32'hffff_fff9);
        close_test("flush", e0);

        collect_prop_failures();
        $display("%0d tests, %0d bad, %0d errors", tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/xalu_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module xalu_props (
    input  logic clk,
    input  logic reset,
    input  logic flush_i,
    input  logic accept_mul_i,
    input  logic accept_div_i,
    input  logic mul_done_i,
    input  logic div_done_i,
    input  logic busy_i
);

    localparam int MUL_BUSY = xalu_data_pkg::MULT_CYCLES + 1;
    localparam int DIV_BUSY = xalu_data_pkg::DIV_CYCLES + 1;

    int fail_count = 0;

    a_idle_after_reset: assert property (@(posedge clk) reset |=> !busy_i)
        else begin
            fail_count++;
            $error("busy set right after reset");
        end

    a_one_done: assert property (@(posedge clk) disable iff (reset)
        !(mul_done_i && div_done_i))
        else begin
            fail_count++;
            $error("multiplier and divider done together");
        end

    // a flush anywhere in the window cancels the check
    a_mul_latency: assert property (@(posedge clk) disable iff (reset || flush_i)
        accept_mul_i |=> busy_i [*MUL_BUSY] ##1 !busy_i)
        else begin
            fail_count++;
            $error("multiply busy window has the wrong length");
        end

    a_div_latency: assert property (@(posedge clk) disable iff (reset || flush_i)
        accept_div_i |=> busy_i [*DIV_BUSY] ##1 !busy_i)
        else begin
            fail_count++;
            $error("divide busy window has the wrong length");
        end

endmodule

bind xalu_hilo_unit xalu_props i_props (
    .clk          (clk),
    .reset        (reset),
    .flush_i      (flush_i),
    .accept_mul_i (accept_mul),
    .accept_div_i (accept_div),
    .mul_done_i   (mul_res_i.done),
    .div_done_i   (div_res_i.done),
    .busy_i       (busy_o)
);

`default_nettype wire

// ==== source/xalu_data_pkg.sv ====
`default_nettype none

package xalu_data_pkg;

    localparam int WORD_W  = 32;
    localparam int DWORD_W = 2 * WORD_W;

    localparam int MULT_CYCLES = 8;                 // one radix-16 step per cycle
    localparam int DIV_CYCLES  = 33;                // sign prep plus one bit per cycle
    localparam int DIV_STEPS   = DIV_CYCLES - 1;    // restoring steps only

    localparam int MULT_CNT_W = $clog2(MULT_CYCLES);
    localparam int DIV_CNT_W  = $clog2(DIV_STEPS);

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [DWORD_W-1:0] dword_t;            // {hi, lo}

    // request from the hi/lo unit into one arithmetic unit
    typedef struct packed {
        logic  start;          // single-cycle pulse
        logic  is_signed;
        word_t a;
        word_t b;
    } unit_req_t;

    typedef struct packed {
        logic   done;          // single-cycle pulse
        dword_t value;
    } unit_res_t;

endpackage

`default_nettype wire

// ==== source/xalu_divider.sv ====
`timescale 1ns/10ps
`default_nettype none

module xalu_divider (
    input  logic                     clk,
    input  logic                     reset,
    input  xalu_data_pkg::unit_req_t req_i,
    input  logic                     abort_i,
    output xalu_data_pkg::unit_res_t res_o
);

    typedef enum logic [1:0] {
        IDLE,
        PREP,
        STEP,
        DONE
    } div_state_t;

    div_state_t                          state;
    logic [xalu_data_pkg::DIV_CNT_W-1:0] step_cnt;
    logic                                last_step;

    xalu_data_pkg::word_t                op_a;      // raw dividend
    xalu_data_pkg::word_t                op_b;      // raw divisor
    logic                                sgn;
    xalu_data_pkg::word_t                mag_a;
    xalu_data_pkg::word_t                mag_b;

    xalu_data_pkg::word_t                rem;
    xalu_data_pkg::word_t                quo;       // dividend bits shift out, quotient in
    xalu_data_pkg::word_t                dvs;
    logic                                neg_q;
    logic                                neg_r;

    // one restoring step, returns {remainder, quotient}
    function automatic xalu_data_pkg::dword_t div_step(xalu_data_pkg::word_t r,
                                                       xalu_data_pkg::word_t q,
                                                       xalu_data_pkg::word_t d);
        logic [32:0] trial;
        logic [32:0] diff;
        trial = {r, q[31]};
        diff  = trial - {1'b0, d};
        if (!diff[32]) begin
            return {diff[31:0], q[30:0], 1'b1};
        end
        return {trial[31:0], q[30:0], 1'b0};      // restore
    endfunction

    always_comb begin
        mag_a = (sgn && op_a[31]) ? -op_a : op_a;
        mag_b = (sgn && op_b[31]) ? -op_b : op_b;
    end

    assign last_step = (int'(step_cnt) == xalu_data_pkg::DIV_STEPS - 1);

    always_ff @(posedge clk) begin
        if (reset || abort_i) begin
            state    <= IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_i.start) begin
                        state <= PREP;
                    end
                end
                PREP: begin
                    state    <= STEP;
                    step_cnt <= 'd1;                  // first bit resolved in prep
                end
                STEP: begin
                    if (last_step) begin
                        state    <= DONE;
                        step_cnt <= '0;
                    end else begin
                        step_cnt <= step_cnt + 1'b1;
                    end
                end
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (req_i.start) begin
                    op_a <= req_i.a;
                    op_b <= req_i.b;
                    sgn  <= req_i.is_signed;
                end
            end
            PREP: begin
                {rem, quo} <= div_step('0, mag_a, mag_b);
                dvs        <= mag_b;
                neg_q      <= sgn && (op_a[31] ^ op_b[31]);
                neg_r      <= sgn && op_a[31];       // remainder follows the dividend
            end
            STEP: {rem, quo} <= div_step(rem, quo, dvs);
            default: ;
        endcase
    end

    always_comb begin
        res_o.done  = (state == DONE);
        res_o.value = {neg_r ? -rem : rem, neg_q ? -quo : quo};
    end

endmodule

`default_nettype wire

// ==== source/xalu_hilo_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module xalu_hilo_unit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       issue_valid_i,
    input  xalu_op_pkg::xalu_issue_t   issue_i,
    input  logic                       flush_i,
    output xalu_data_pkg::unit_req_t   mul_req_o,
    output xalu_data_pkg::unit_req_t   div_req_o,
    output logic                       abort_o,
    input  xalu_data_pkg::unit_res_t   mul_res_i,
    input  xalu_data_pkg::unit_res_t   div_res_i,
    output xalu_data_pkg::word_t       hi_o,
    output xalu_data_pkg::word_t       lo_o,
    output logic                       busy_o
);

    typedef enum logic [1:0] {
        ACC_NONE,
        ACC_ADD,
        ACC_SUB
    } acc_mode_t;

    logic                  accept;
    logic                  accept_mul;
    logic                  accept_div;
    acc_mode_t             next_mode;

    logic                  busy_q;
    logic                  wait_div;      // operation in flight is a divide
    acc_mode_t             acc_mode;
    logic                  mul_start_q;
    logic                  div_start_q;
    logic                  sign_q;
    xalu_data_pkg::word_t  a_q;
    xalu_data_pkg::word_t  b_q;

    xalu_data_pkg::word_t  hi_q;
    xalu_data_pkg::word_t  lo_q;
    xalu_data_pkg::dword_t hilo;
    xalu_data_pkg::dword_t mul_sum;
    logic                  mul_done;
    logic                  div_done;

    assign accept     = issue_valid_i && !busy_q && !flush_i &&
                        (issue_i.op != xalu_op_pkg::OP_NOP);
    assign accept_mul = accept && xalu_op_pkg::is_mul_op(issue_i.op);
    assign accept_div = accept && xalu_op_pkg::is_div_op(issue_i.op);

    // ignore a done that does not belong to the operation in flight
    assign mul_done = busy_q && !wait_div && mul_res_i.done;
    assign div_done = busy_q && wait_div && div_res_i.done;

    assign abort_o = flush_i && busy_q;                 // nothing to cancel when idle

    always_comb begin
        case (issue_i.op)
            xalu_op_pkg::OP_MADD, xalu_op_pkg::OP_MADDU: next_mode = ACC_ADD;
            xalu_op_pkg::OP_MSUB, xalu_op_pkg::OP_MSUBU: next_mode = ACC_SUB;
            default:                                     next_mode = ACC_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q      <= 1'b0;
            wait_div    <= 1'b0;
            acc_mode    <= ACC_NONE;
            mul_start_q <= 1'b0;
            div_start_q <= 1'b0;
        end else begin
            mul_start_q <= accept_mul;                  // start one edge after acceptance
            div_start_q <= accept_div;
            if (flush_i) begin
                busy_q <= 1'b0;
            end else if (accept_mul || accept_div) begin
                busy_q   <= 1'b1;
                wait_div <= accept_div;
                acc_mode <= next_mode;
            end else if (mul_done || div_done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // operand capture
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q    <= issue_i.a;
            b_q    <= issue_i.b;
            sign_q <= xalu_op_pkg::is_signed_op(issue_i.op);
        end
    end

    always_comb begin
        mul_req_o.start     = mul_start_q;
        mul_req_o.is_signed = sign_q;
        mul_req_o.a         = a_q;
        mul_req_o.b         = b_q;
        div_req_o.start     = div_start_q;
        div_req_o.is_signed = sign_q;
        div_req_o.a         = a_q;
        div_req_o.b         = b_q;
    end

    assign hilo = {hi_q, lo_q};

    // accumulate wraps modulo 2^64 for both signed and unsigned forms
    always_comb begin
        case (acc_mode)
            ACC_ADD: mul_sum = hilo + mul_res_i.value;
            ACC_SUB: mul_sum = hilo - mul_res_i.value;
            default: mul_sum = mul_res_i.value;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (!flush_i) begin
            if (accept && issue_i.op == xalu_op_pkg::OP_MTHI) begin
                hi_q <= issue_i.a;
            end else if (accept && issue_i.op == xalu_op_pkg::OP_MTLO) begin
                lo_q <= issue_i.a;
            end else if (mul_done) begin
                {hi_q, lo_q} <= mul_sum;
            end else if (div_done) begin
                {hi_q, lo_q} <= div_res_i.value;    // remainder to hi, quotient to lo
            end
        end
    end

    assign hi_o   = hi_q;
    assign lo_o   = lo_q;
    assign busy_o = busy_q;

endmodule

`default_nettype wire

// ==== source/xalu_multiplier.sv ====
`timescale 1ns/10ps
`default_nettype none

module xalu_multiplier (
    input  logic                     clk,
    input  logic                     reset,
    input  xalu_data_pkg::unit_req_t req_i,
    input  logic                     abort_i,
    output xalu_data_pkg::unit_res_t res_o
);

    xalu_data_pkg::word_t                 in_mag_a;
    xalu_data_pkg::word_t                 in_mag_b;
    logic                                 in_neg;

    logic                                 running;
    logic [xalu_data_pkg::MULT_CNT_W-1:0] step_cnt;   // steps already taken
    logic                                 last_step;
    logic                                 done_q;

    xalu_data_pkg::word_t                 mag_a;      // multiplicand magnitude
    xalu_data_pkg::word_t                 mag_b;      // consumed msb nibble first
    xalu_data_pkg::dword_t                acc;
    logic                                 prod_neg;

    always_comb begin
        in_mag_a = (req_i.is_signed && req_i.a[31]) ? -req_i.a : req_i.a;
        in_mag_b = (req_i.is_signed && req_i.b[31]) ? -req_i.b : req_i.b;
        in_neg   = req_i.is_signed && (req_i.a[31] ^ req_i.b[31]);
    end

    assign last_step = running && (int'(step_cnt) == xalu_data_pkg::MULT_CYCLES - 1);

    always_ff @(posedge clk) begin
        if (reset || abort_i) begin
            running  <= 1'b0;
            step_cnt <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= last_step;                      // product complete after this edge
            if (req_i.start) begin
                running  <= 1'b1;
                step_cnt <= 'd1;                      // top nibble taken on the start edge
            end else if (last_step) begin
                running  <= 1'b0;
                step_cnt <= '0;
            end else if (running) begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    // shift-add datapath, four multiplier bits per edge
    always_ff @(posedge clk) begin
        if (req_i.start) begin
            mag_a    <= in_mag_a;
            mag_b    <= in_mag_b << 4;
            acc      <= xalu_data_pkg::dword_t'(in_mag_a) *
                        xalu_data_pkg::dword_t'(in_mag_b[31:28]);
            prod_neg <= in_neg;
        end else if (running) begin
            mag_b <= mag_b << 4;
            acc   <= (acc << 4) +
                     xalu_data_pkg::dword_t'(mag_a) * xalu_data_pkg::dword_t'(mag_b[31:28]);
        end
    end

    always_comb begin
        res_o.done  = done_q;
        res_o.value = prod_neg ? -acc : acc;          // two's complement of the magnitude
    end

endmodule

`default_nettype wire

// ==== source/xalu_op_pkg.sv ====
`default_nettype none

package xalu_op_pkg;

    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_MULT  = 4'd1,
        OP_MULTU = 4'd2,
        OP_MADD  = 4'd3,
        OP_MADDU = 4'd4,
        OP_MSUB  = 4'd5,
        OP_MSUBU = 4'd6,
        OP_DIV   = 4'd7,
        OP_DIVU  = 4'd8,
        OP_MTHI  = 4'd9,
        OP_MTLO  = 4'd10
    } xalu_op_t;

    typedef struct packed {
        xalu_op_t             op;
        xalu_data_pkg::word_t a;     // rs
        xalu_data_pkg::word_t b;     // rt
    } xalu_issue_t;

    // all forms that go through the multiplier
    function automatic logic is_mul_op(xalu_op_t op);
        return op inside {OP_MULT, OP_MULTU, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    endfunction

    function automatic logic is_div_op(xalu_op_t op);
        return op inside {OP_DIV, OP_DIVU};
    endfunction

    function automatic logic is_signed_op(xalu_op_t op);
        return op inside {OP_MULT, OP_MADD, OP_MSUB, OP_DIV};
    endfunction

endpackage

`default_nettype wire

// ==== source/xalu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module xalu_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     issue_valid_i,
    input  xalu_op_pkg::xalu_issue_t issue_i,
    input  logic                     flush_i,
    output xalu_data_pkg::word_t     hi_o,
    output xalu_data_pkg::word_t     lo_o,
    output logic                     busy_o
);

    xalu_data_pkg::unit_req_t mul_req;
    xalu_data_pkg::unit_req_t div_req;
    xalu_data_pkg::unit_res_t mul_res;
    xalu_data_pkg::unit_res_t div_res;
    logic                     abort;      // shared by both units

    xalu_hilo_unit i_hilo (
        .clk           (clk),
        .reset         (reset),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .flush_i       (flush_i),
        .mul_req_o     (mul_req),
        .div_req_o     (div_req),
        .abort_o       (abort),
        .mul_res_i     (mul_res),
        .div_res_i     (div_res),
        .hi_o          (hi_o),
        .lo_o          (lo_o),
        .busy_o        (busy_o)
    );

    xalu_multiplier i_mul (
        .clk     (clk),
        .reset   (reset),
        .req_i   (mul_req),
        .abort_i (abort),
        .res_o   (mul_res)
    );

    xalu_divider i_div (
        .clk     (clk),
        .reset   (reset),
        .req_i   (div_req),
        .abort_i (abort),
        .res_o   (div_res)
    );

endmodule

`default_nettype wire

// ==== src.f ====
source/xalu_data_pkg.sv
source/xalu_op_pkg.sv
source/xalu_multiplier.sv
source/xalu_divider.sv
source/xalu_hilo_unit.sv
source/xalu_top.sv
bench/xalu_props.sv
bench/tb_xalu.sv
